//--- src/pulse_pkg.sv
`default_nettype none

package pulse_pkg;

   localparam int unsigned time_w  = 32;               // Period counter and all edge times
   localparam int unsigned width_w = 16;               // Width and delay settings
   localparam int unsigned pad_w   = time_w - width_w; // Zero fill when widening a setting
   localparam int unsigned att_w   = 7;                // Attenuator word
   localparam int unsigned addr_w  = 4;                // Register address

   localparam logic [att_w-1:0]  att_step     = 7'd6;     // Added while transmitting
   localparam logic [att_w-1:0]  att_max      = 7'd127;   // Saturation level
   localparam logic [time_w-1:0] guard_end    = 32'd20;   // Raised attenuation before wrap
   localparam logic [time_w-1:0] reset_period = 32'd10000;

   // Register map, addresses 14 and 15 unused
   localparam logic [addr_w-1:0] reg_period    = 4'd0;
   localparam logic [addr_w-1:0] reg_p1_width  = 4'd1;
   localparam logic [addr_w-1:0] reg_delay     = 4'd2;
   localparam logic [addr_w-1:0] reg_p2_width  = 4'd3;
   localparam logic [addr_w-1:0] reg_mode      = 4'd4;  // 0 CW, 1 Hahn, N CPMG
   localparam logic [addr_w-1:0] reg_block_gap = 4'd5;
   localparam logic [addr_w-1:0] reg_block_en  = 4'd6;
   localparam logic [addr_w-1:0] reg_att       = 4'd7;
   localparam logic [addr_w-1:0] reg_p1_start2 = 4'd8;  // Channel 2 pulse pair
   localparam logic [addr_w-1:0] reg_p1_width2 = 4'd9;
   localparam logic [addr_w-1:0] reg_delay2    = 4'd10;
   localparam logic [addr_w-1:0] reg_p2_width2 = 4'd11;
   localparam logic [addr_w-1:0] reg_nut_width = 4'd12; // Nutation pulse at period end
   localparam logic [addr_w-1:0] reg_nut_delay = 4'd13;

endpackage

`default_nettype wire

//--- src/pulse_config.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_config (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             cfg_valid,
   input  logic [pulse_pkg::addr_w-1:0]     cfg_addr,
   input  logic [pulse_pkg::time_w-1:0]     cfg_data,
   input  logic                             period_wrap,
   output logic                             cfg_ready,
   output logic [pulse_pkg::time_w-1:0]     period,
   output logic [pulse_pkg::width_w-1:0]    p1_width,
   output logic [pulse_pkg::width_w-1:0]    delay,
   output logic [pulse_pkg::width_w-1:0]    p2_width,
   output logic [pulse_pkg::width_w-1:0]    block_gap,
   output logic [pulse_pkg::width_w-1:0]    p1_start2,
   output logic [pulse_pkg::width_w-1:0]    p1_width2,
   output logic [pulse_pkg::width_w-1:0]    delay2,
   output logic [pulse_pkg::width_w-1:0]    p2_width2,
   output logic [pulse_pkg::width_w-1:0]    nut_width,
   output logic [pulse_pkg::width_w-1:0]    nut_delay,
   output logic [pulse_pkg::width_w-1:0]    mode,      // Active copy
   output logic                             block_en,  // Active copy
   output logic [pulse_pkg::att_w-1:0]      att        // Active copy
);

   logic [pulse_pkg::width_w-1:0] mode_s;      // Shadow of mode
   logic                          block_en_s;  // Shadow of block_en
   logic [pulse_pkg::att_w-1:0]   att_s;       // Shadow of att

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg_ready  <= 1'b0;
         period     <= pulse_pkg::reset_period;
         p1_width   <= '0;
         delay      <= '0;
         p2_width   <= '0;
         block_gap  <= '0;
         p1_start2  <= '0;
         p1_width2  <= '0;
         delay2     <= '0;
         p2_width2  <= '0;
         nut_width  <= '0;
         nut_delay  <= '0;
         mode_s     <= '0;
         block_en_s <= 1'b0;
         att_s      <= '0;
         mode       <= '0;
         block_en   <= 1'b0;
         att        <= '0;
      end else begin
         cfg_ready <= 1'b1;                   // Port never stalls
         if (cfg_valid && cfg_ready) begin
            case (cfg_addr)
               pulse_pkg::reg_period:    period     <= cfg_data;
               pulse_pkg::reg_p1_width:  p1_width   <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_delay:     delay      <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_p2_width:  p2_width   <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_mode:      mode_s     <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_block_gap: block_gap  <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_block_en:  block_en_s <= cfg_data[0];
               pulse_pkg::reg_att:       att_s      <= cfg_data[pulse_pkg::att_w-1:0];
               pulse_pkg::reg_p1_start2: p1_start2  <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_p1_width2: p1_width2  <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_delay2:    delay2     <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_p2_width2: p2_width2  <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_nut_width: nut_width  <= cfg_data[pulse_pkg::width_w-1:0];
               pulse_pkg::reg_nut_delay: nut_delay  <= cfg_data[pulse_pkg::width_w-1:0];
               default: ;                     // Spare addresses swallow the write
            endcase
         end
         if (period_wrap) begin               // New set valid from counter 0
            mode     <= mode_s;
            block_en <= block_en_s;
            att      <= att_s;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/pulse_timing.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_timing (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [pulse_pkg::time_w-1:0]  period,
   input  logic [pulse_pkg::width_w-1:0] p1_width,
   input  logic [pulse_pkg::width_w-1:0] delay,
   input  logic [pulse_pkg::width_w-1:0] p2_width,
   input  logic [pulse_pkg::width_w-1:0] block_gap,
   input  logic [pulse_pkg::width_w-1:0] p1_start2,
   input  logic [pulse_pkg::width_w-1:0] p1_width2,
   input  logic [pulse_pkg::width_w-1:0] delay2,
   input  logic [pulse_pkg::width_w-1:0] p2_width2,
   input  logic [pulse_pkg::width_w-1:0] nut_width,
   input  logic [pulse_pkg::width_w-1:0] nut_delay,
   output logic [pulse_pkg::time_w-1:0]  period_lim,
   output logic [pulse_pkg::time_w-1:0]  p1_end,
   output logic [pulse_pkg::time_w-1:0]  pi_first_start,
   output logic [pulse_pkg::time_w-1:0]  pi_step,
   output logic [pulse_pkg::time_w-1:0]  p2_width_t,
   output logic [pulse_pkg::time_w-1:0]  sync_end,
   output logic [pulse_pkg::time_w-1:0]  win_open_off,
   output logic [pulse_pkg::time_w-1:0]  win_close_off,
   output logic [pulse_pkg::time_w-1:0]  p2a_start,
   output logic [pulse_pkg::time_w-1:0]  p2a_end,
   output logic [pulse_pkg::time_w-1:0]  p2b_start,
   output logic [pulse_pkg::time_w-1:0]  p2b_end,
   output logic [pulse_pkg::time_w-1:0]  nut_start,
   output logic [pulse_pkg::time_w-1:0]  nut_end,
   output logic [pulse_pkg::time_w-1:0]  guard_start
);

   logic [pulse_pkg::time_w-1:0] p1w, dly, p2w, gap, st2, w2a, dly2, w2b, nw, nd;

   assign p1w  = {{pulse_pkg::pad_w{1'b0}}, p1_width};   // Settings widened to edge width
   assign dly  = {{pulse_pkg::pad_w{1'b0}}, delay};
   assign p2w  = {{pulse_pkg::pad_w{1'b0}}, p2_width};
   assign gap  = {{pulse_pkg::pad_w{1'b0}}, block_gap};
   assign st2  = {{pulse_pkg::pad_w{1'b0}}, p1_start2};
   assign w2a  = {{pulse_pkg::pad_w{1'b0}}, p1_width2};
   assign dly2 = {{pulse_pkg::pad_w{1'b0}}, delay2};
   assign w2b  = {{pulse_pkg::pad_w{1'b0}}, p2_width2};
   assign nw   = {{pulse_pkg::pad_w{1'b0}}, nut_width};
   assign nd   = {{pulse_pkg::pad_w{1'b0}}, nut_delay};

   always_ff @(posedge clk) begin
      if (!rst_n) begin                       // Edges of the reset settings
         period_lim     <= pulse_pkg::reset_period;
         p1_end         <= '0;
         pi_first_start <= '0;
         pi_step        <= '0;
         p2_width_t     <= '0;
         sync_end       <= '0;
         win_open_off   <= '0;
         win_close_off  <= '0;
         p2a_start      <= '0;
         p2a_end        <= '0;
         p2b_start      <= '0;
         p2b_end        <= '0;
         nut_start      <= pulse_pkg::reset_period;
         nut_end        <= pulse_pkg::reset_period;
         guard_start    <= pulse_pkg::reset_period - pulse_pkg::guard_end;
      end else begin
         period_lim     <= period;
         p1_end         <= p1w;
         pi_first_start <= p1w + dly;               // Start of refocusing pulse 0
         pi_step        <= dly + dly + p2w;         // Spacing of refocusing pulses
         p2_width_t     <= p2w;
         sync_end       <= p1w + dly + p2w;
         win_open_off   <= p2w + gap;               // Offsets from each pulse start
         // Window closed entirely once the gap eats the whole delay
         win_close_off  <= (gap >= dly) ? p2w + gap : p2w + dly + dly - gap;
         p2a_start      <= st2;
         p2a_end        <= st2 + w2a;
         p2b_start      <= st2 + w2a + dly2;
         p2b_end        <= st2 + w2a + dly2 + w2b;
         nut_start      <= period - nd - nw;        // Nutation ends nut_delay before wrap
         nut_end        <= period - nd;
         guard_start    <= (period >= pulse_pkg::guard_end) ? period - pulse_pkg::guard_end : '0;
      end
   end

endmodule

`default_nettype wire

//--- src/pulse_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_sequencer (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [pulse_pkg::time_w-1:0]  period_lim,
   input  logic [pulse_pkg::time_w-1:0]  p1_end,
   input  logic [pulse_pkg::time_w-1:0]  pi_first_start,
   input  logic [pulse_pkg::time_w-1:0]  pi_step,
   input  logic [pulse_pkg::time_w-1:0]  p2_width_t,
   input  logic [pulse_pkg::time_w-1:0]  sync_end,
   input  logic [pulse_pkg::time_w-1:0]  win_open_off,
   input  logic [pulse_pkg::time_w-1:0]  win_close_off,
   input  logic [pulse_pkg::time_w-1:0]  p2a_start,
   input  logic [pulse_pkg::time_w-1:0]  p2a_end,
   input  logic [pulse_pkg::time_w-1:0]  p2b_start,
   input  logic [pulse_pkg::time_w-1:0]  p2b_end,
   input  logic [pulse_pkg::time_w-1:0]  nut_start,
   input  logic [pulse_pkg::time_w-1:0]  nut_end,
   input  logic [pulse_pkg::width_w-1:0] mode,
   input  logic                          block_en,
   output logic                          period_wrap,
   output logic [pulse_pkg::time_w-1:0]  count,
   output logic                          sync_on,
   output logic                          pulse1_on,
   output logic                          pulse2_on,
   output logic                          tx_first,
   output logic                          echo_window
);

   logic [pulse_pkg::time_w-1:0]  per_q, sync_end_q;          // Period and sync edge in force
   logic [pulse_pkg::time_w-1:0]  p1_end_q, step_q, p2w_q, open_q, close_q;
   logic [pulse_pkg::time_w-1:0]  p2a_s_q, p2a_e_q, p2b_s_q, p2b_e_q, nut_s_q, nut_e_q;
   logic [pulse_pkg::time_w-1:0]  next_start;                 // Start of current pi pulse
   logic [pulse_pkg::time_w-1:0]  rel;                        // Counter relative to it
   logic [pulse_pkg::width_w-1:0] pi_idx;                     // Refocusing pulses passed
   logic                          train_on, pi_on, win_on, ch2_first, ch2_on;

   assign period_wrap = (count == per_q);
   assign rel         = count - next_start;
   assign train_on    = (count >= next_start) && (pi_idx < mode);   // Inside slot k < N
   assign pi_on       = train_on && (rel < p2w_q);                  // Empty when p2_width 0
   assign win_on      = train_on && (rel >= open_q) && (rel < close_q);
   assign ch2_first   = (count >= p2a_s_q) && (count < p2a_e_q);
   assign ch2_on      = ch2_first
                        || ((count >= p2b_s_q) && (count < p2b_e_q))
                        || ((count >= nut_s_q) && (count < nut_e_q));

   always_ff @(posedge clk) begin
      if (period_wrap) begin                  // Pulse edges of the next period
         p1_end_q <= p1_end;
         step_q   <= pi_step;
         p2w_q    <= p2_width_t;
         open_q   <= win_open_off;
         close_q  <= win_close_off;
         p2a_s_q  <= p2a_start;
         p2a_e_q  <= p2a_end;
         p2b_s_q  <= p2b_start;
         p2b_e_q  <= p2b_end;
         nut_s_q  <= nut_start;
         nut_e_q  <= nut_end;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count       <= '0;
         per_q       <= pulse_pkg::reset_period;
         sync_end_q  <= '0;
         next_start  <= '0;
         pi_idx      <= '0;
         sync_on     <= 1'b0;
         pulse1_on   <= 1'b0;
         pulse2_on   <= 1'b0;
         tx_first    <= 1'b0;
         echo_window <= 1'b0;
      end else begin
         sync_on <= (count < sync_end_q);     // Scope trigger
         if (period_wrap) begin               // Restart period and CPMG walker
            count      <= '0;
            per_q      <= period_lim;
            sync_end_q <= sync_end;
            next_start <= pi_first_start;
            pi_idx     <= '0;
         end else begin
            count <= count + 1'b1;
            if (train_on && (rel == step_q - 1'b1)) begin   // Last cycle of slot k
               next_start <= next_start + step_q;
               pi_idx     <= pi_idx + 1'b1;
            end
         end
         if (mode == '0) begin                // CW, switches static
            pulse1_on   <= ~block_en;
            pulse2_on   <= block_en;
            tx_first    <= 1'b0;
            echo_window <= 1'b0;
         end else begin
            pulse1_on   <= (count < p1_end_q) || pi_on;
            pulse2_on   <= ch2_on;
            tx_first    <= (count < p1_end_q) || ch2_first;
            echo_window <= win_on;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/receiver_protect.sv
`timescale 1ns/1ps
`default_nettype none

module receiver_protect (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [pulse_pkg::time_w-1:0]  count,
   input  logic [pulse_pkg::time_w-1:0]  guard_start,
   input  logic [pulse_pkg::width_w-1:0] mode,
   input  logic                          block_en,
   input  logic [pulse_pkg::att_w-1:0]   att,
   input  logic                          pulse1_on,
   input  logic                          pulse2_on,
   input  logic                          tx_first,
   input  logic                          echo_window,
   output logic [pulse_pkg::att_w-1:0]   pre_att,
   output logic                          pre_block,
   output logic                          inhib
);

   logic [pulse_pkg::time_w-1:0]  count_d;     // Counter aligned with the pulse flags
   logic [pulse_pkg::time_w-1:0]  guard_q;     // Guard edge of the running period
   logic [pulse_pkg::width_w-1:0] mode_d;
   logic                          block_en_d;
   logic [pulse_pkg::att_w-1:0]   att_d;
   logic [pulse_pkg::att_w:0]     att_sum;     // One bit of headroom for the step
   logic [pulse_pkg::att_w-1:0]   att_hi;

   assign att_sum = {1'b0, att_d} + {1'b0, pulse_pkg::att_step};
   assign att_hi  = (att_sum > {1'b0, pulse_pkg::att_max}) ? pulse_pkg::att_max
                                                           : att_sum[pulse_pkg::att_w-1:0];

   always_ff @(posedge clk) begin
      count_d    <= count;
      mode_d     <= mode;                     // Active set switches one cycle late here
      block_en_d <= block_en;
      att_d      <= att;
      if (count == '0)                        // Same shadow set as the wrap commit
         guard_q <= guard_start;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pre_att   <= '0;
         pre_block <= 1'b0;
         inhib     <= 1'b0;
      end else if (mode_d == '0) begin        // CW
         pre_att   <= att_d;
         pre_block <= 1'b1;
         inhib     <= 1'b0;
      end else begin
         pre_att   <= (tx_first || (count_d >= guard_q)) ? att_hi : att_d;
         pre_block <= pulse1_on | pulse2_on;
         inhib     <= block_en_d & ~echo_window;   // Open only for echoes
      end
   end

endmodule

`default_nettype wire

//--- src/pulse_top.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_top (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         cfg_valid,
   input  logic [pulse_pkg::addr_w-1:0] cfg_addr,
   input  logic [pulse_pkg::time_w-1:0] cfg_data,
   output logic                         cfg_ready,
   output logic                         sync_on,
   output logic                         pulse1_on,
   output logic                         pulse2_on,
   output logic [pulse_pkg::att_w-1:0]  pre_att,
   output logic                         pre_block,
   output logic                         inhib
);

   logic [pulse_pkg::time_w-1:0]  period;                 // Shadow settings
   logic [pulse_pkg::width_w-1:0] p1_width, delay, p2_width, block_gap;
   logic [pulse_pkg::width_w-1:0] p1_start2, p1_width2, delay2, p2_width2;
   logic [pulse_pkg::width_w-1:0] nut_width, nut_delay;
   logic [pulse_pkg::width_w-1:0] mode;                   // Active settings
   logic                          block_en;
   logic [pulse_pkg::att_w-1:0]   att;
   logic [pulse_pkg::time_w-1:0]  period_lim, p1_end, pi_first_start, pi_step, p2_width_t;
   logic [pulse_pkg::time_w-1:0]  sync_end, win_open_off, win_close_off;
   logic [pulse_pkg::time_w-1:0]  p2a_start, p2a_end, p2b_start, p2b_end;
   logic [pulse_pkg::time_w-1:0]  nut_start, nut_end, guard_start;
   logic                          period_wrap;
   logic [pulse_pkg::time_w-1:0]  count;
   logic                          tx_first, echo_window;

   pulse_config pulse_config_inst (
      .clk, .rst_n, .cfg_valid, .cfg_addr, .cfg_data, .period_wrap, .cfg_ready,
      .period, .p1_width, .delay, .p2_width, .block_gap,
      .p1_start2, .p1_width2, .delay2, .p2_width2, .nut_width, .nut_delay,
      .mode, .block_en, .att
   );

   pulse_timing pulse_timing_inst (
      .clk, .rst_n, .period, .p1_width, .delay, .p2_width, .block_gap,
      .p1_start2, .p1_width2, .delay2, .p2_width2, .nut_width, .nut_delay,
      .period_lim, .p1_end, .pi_first_start, .pi_step, .p2_width_t,
      .sync_end, .win_open_off, .win_close_off,
      .p2a_start, .p2a_end, .p2b_start, .p2b_end, .nut_start, .nut_end, .guard_start
   );

   pulse_sequencer pulse_sequencer_inst (
      .clk, .rst_n, .period_lim, .p1_end, .pi_first_start, .pi_step, .p2_width_t,
      .sync_end, .win_open_off, .win_close_off,
      .p2a_start, .p2a_end, .p2b_start, .p2b_end, .nut_start, .nut_end,
      .mode, .block_en, .period_wrap, .count,
      .sync_on, .pulse1_on, .pulse2_on, .tx_first, .echo_window
   );

   receiver_protect receiver_protect_inst (
      .clk, .rst_n, .count, .guard_start, .mode, .block_en, .att,
      .pulse1_on, .pulse2_on, .tx_first, .echo_window,
      .pre_att, .pre_block, .inhib
   );

endmodule

`default_nettype wire

//--- testbench/pulse_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_tb;

   localparam int max_period  = 1200;                  // Longest period any test programs
   localparam int max_periods = 40;                    // Upper bound on periods run
   localparam int watchdog_ns = (10001 + max_periods * (max_period + 1) + 2000) * 4;

   logic        clk;
   logic        rst_n;
   logic        cfg_valid;
   logic [3:0]  cfg_addr;
   logic [31:0] cfg_data;
   logic        cfg_ready, sync_on, pulse1_on, pulse2_on, pre_block, inhib;
   logic [6:0]  pre_att;

   logic [13:0][31:0] cfg;                             // Settings the next write burst sends
   logic [13:0][31:0] shd_set;                         // Model of the shadow registers
   logic [13:0][31:0] act_set;                         // Model of the running period's set
   logic [31:0]       m_count;                         // Model counter seen by the DUT
   logic [11:0]       exp_pulse, exp_rx;               // Expected words, one and two deep
   logic [31:0]       rng = 32'h1464_9479;
   int                wraps;
   int                errors = 0;
   string             cur_test = "reset";

   pulse_top pulse_top_inst (
      .clk, .rst_n, .cfg_valid, .cfg_addr, .cfg_data, .cfg_ready,
      .sync_on, .pulse1_on, .pulse2_on, .pre_att, .pre_block, .inhib
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                           // 4 ns period
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] pick(input logic [31:0] lo, input logic [31:0] hi);
      rng = xorshift(rng);
      return lo + rng % (hi - lo + 1);
   endfunction

   function automatic logic [13:0][31:0] default_settings();
      logic [13:0][31:0] s;
      s = '0;
      s[pulse_pkg::reg_period] = 32'd10000;            // Only nonzero reset setting
      return s;
   endfunction

   function automatic logic [31:0] masked_setting(input logic [3:0] addr, input logic [31:0] d);
      case (addr)
         pulse_pkg::reg_period:   return d;
         pulse_pkg::reg_block_en: return {31'b0, d[0]};
         pulse_pkg::reg_att:      return {25'b0, d[6:0]};
         default:                 return {16'b0, d[15:0]};
      endcase
   endfunction

   // Expected {sync, pulse1, pulse2, pre_att, pre_block, inhib} for counter value c
   function automatic logic [11:0] expected_word(input logic [13:0][31:0] s,
                                                 input logic [31:0] c);
      logic [31:0] per, p1, d, p2, md, gap, st2, w2a, d2, w2b, nw, nd, ps, pe;
      logic        ben, sync, pa, pb, first, win, blk, inh;
      logic [6:0]  att, hi, ao;
      int          sum;
      int unsigned k;
      per = s[0];
      p1  = s[1];
      d   = s[2];
      p2  = s[3];
      md  = s[4];
      gap = s[5];
      ben = s[6][0];
      att = s[7][6:0];
      st2 = s[8];
      w2a = s[9];
      d2  = s[10];
      w2b = s[11];
      nw  = s[12];
      nd  = s[13];
      sync  = (c < p1 + d + p2);
      first = (c >= st2) && (c < st2 + w2a);           // First pulse of channel 2
      win   = 1'b0;
      sum   = int'(att) + int'(pulse_pkg::att_step);   // Raised level before the cap
      hi    = (sum > int'(pulse_pkg::att_max)) ? pulse_pkg::att_max : 7'(sum);
      if (md == 0) begin                               // CW, static switches
         pa  = ~ben;
         pb  = ben;
         inh = 1'b0;
         blk = 1'b1;
         ao  = att;
      end else begin
         pa = (c < p1);
         for (k = 0; k < md; k++) begin                // Walk all refocusing pulses
            ps = p1 + d + k * (d + d + p2);
            pe = ps + p2;
            if (p2 > 0 && c >= ps && c < pe)
               pa = 1'b1;
            if (gap < d && c >= pe + gap && c < pe + d + d - gap)
               win = 1'b1;
         end
         pb = first
              || (c >= st2 + w2a + d2 && c < st2 + w2a + d2 + w2b)
              || (c >= per - nd - nw && c < per - nd);  // Nutation pulse
         inh = ben & ~win;
         blk = pa | pb;
         ao  = (c < p1 || first || c + pulse_pkg::guard_end >= per) ? hi : att;
      end
      return {sync, pa, pb, ao, blk, inh};
   endfunction

   task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
      end
   endtask

   always @(posedge clk) begin                         // Shadow registers take accepted writes
      if (!rst_n)
         shd_set <= default_settings();
      else if (cfg_valid && cfg_ready && cfg_addr < 4'd14)
         shd_set[cfg_addr] <= masked_setting(cfg_addr, cfg_data);
   end

   always @(negedge clk) begin                         // Model and compare, once per cycle
      if (!rst_n) begin
         act_set   = default_settings();
         m_count   = 32'd1;                            // DUT counter one cycle after release
         exp_pulse = expected_word(act_set, 32'd0);
         exp_rx    = exp_pulse;                        // Receiver starts in CW from reset
         wraps     = 0;
      end else begin
         check({cur_test, " pulses"}, 32'(exp_pulse[11:9]), 32'({sync_on, pulse1_on, pulse2_on}));
         check({cur_test, " receiver"}, 32'(exp_rx[8:0]), 32'({pre_att, pre_block, inhib}));
         check({cur_test, " cfg_ready"}, 32'd1, 32'(cfg_ready));
         exp_rx    = exp_pulse;                        // Receiver outputs lag one more cycle
         exp_pulse = expected_word(act_set, m_count);
         if (m_count == act_set[0]) begin              // Wrap commits the shadow set
            act_set = shd_set;
            m_count = 32'd0;
            wraps++;
         end else begin
            m_count++;
         end
      end
   end

   task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
      @(negedge clk);
      while (!cfg_ready)                               // Port takes a write only when ready
         @(negedge clk);
      cfg_valid <= 1'b1;
      cfg_addr  <= addr;
      cfg_data  <= data;
      @(negedge clk);
      cfg_valid <= 1'b0;
   endtask

   task automatic wait_safe();                         // Keep a burst clear of the wrap
      while (!(m_count >= 4 && m_count + 48 < act_set[0]))
         @(negedge clk);
   endtask

   task automatic write_all();
      logic [31:0] junk;
      wait_safe();
      for (int a = 0; a < 16; a++) begin
         junk = pick(0, 32'hffff_fffe);
         if (a >= 14)
            write_reg(4'(a), junk);                    // Spare addresses
         else if (a == 0)
            write_reg(4'(a), cfg[a]);
         else
            write_reg(4'(a), cfg[a] | {junk[15:0], 16'h0});   // Upper bits masked off
      end
   endtask

   task automatic wait_wraps(input int n);
      int target;
      target = wraps + n;
      while (wraps < target)
         @(negedge clk);
   endtask

   initial begin
      rst_n     = 1'b0;
      cfg_valid = 1'b0;
      cfg_addr  = 4'd0;
      cfg_data  = 32'd0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      check("reset", 32'd0,
            32'({cfg_ready, sync_on, pulse1_on, pulse2_on, pre_att, pre_block, inhib}));
      rst_n <= 1'b1;
      repeat (20) @(negedge clk);

      cur_test = "cw";
      cfg = '0;
      cfg[pulse_pkg::reg_period] = 32'd300;
      cfg[pulse_pkg::reg_att]    = 32'd33;
      write_all();
      wait_wraps(2);
      cfg[pulse_pkg::reg_block_en] = 32'd1;
      write_all();
      wait_wraps(2);

      cur_test = "hahn";
      cfg = '0;
      cfg[pulse_pkg::reg_period]    = 32'd400;
      cfg[pulse_pkg::reg_p1_width]  = 32'd10;
      cfg[pulse_pkg::reg_delay]     = 32'd40;
      cfg[pulse_pkg::reg_p2_width]  = 32'd20;
      cfg[pulse_pkg::reg_mode]      = 32'd1;
      cfg[pulse_pkg::reg_block_gap] = 32'd5;
      cfg[pulse_pkg::reg_block_en]  = 32'd1;
      cfg[pulse_pkg::reg_att]       = 32'd50;
      write_all();
      wait_wraps(3);

      cur_test = "cpmg";
      for (int i = 0; i < 4; i++) begin
         cfg = '0;
         cfg[pulse_pkg::reg_mode]      = pick(2, 6);
         cfg[pulse_pkg::reg_p1_width]  = pick(1, 20);
         cfg[pulse_pkg::reg_delay]     = pick(5, 40);
         cfg[pulse_pkg::reg_p2_width]  = (i == 1) ? 32'd0 : pick(1, 20);
         cfg[pulse_pkg::reg_block_gap] = pick(0, cfg[pulse_pkg::reg_delay]);
         cfg[pulse_pkg::reg_block_en]  = 32'd1;
         cfg[pulse_pkg::reg_att]       = pick(0, 100);
         cfg[pulse_pkg::reg_period]    = cfg[1] + cfg[2] + cfg[4] * (cfg[2] + cfg[2] + cfg[3])
                                         + pick(50, 150);
         write_all();
         wait_wraps(2);
      end

      cur_test = "channel2";
      for (int i = 0; i < 3; i++) begin
         cfg[pulse_pkg::reg_mode]      = pick(1, 3);
         cfg[pulse_pkg::reg_p1_width]  = pick(1, 20);
         cfg[pulse_pkg::reg_delay]     = pick(5, 30);
         cfg[pulse_pkg::reg_p2_width]  = pick(1, 10);
         cfg[pulse_pkg::reg_block_gap] = pick(0, 4);
         cfg[pulse_pkg::reg_att]       = pick(122, 127);    // Step saturates here
         cfg[pulse_pkg::reg_p1_start2] = pick(0, 50);
         cfg[pulse_pkg::reg_p1_width2] = pick(1, 20);
         cfg[pulse_pkg::reg_delay2]    = pick(1, 30);
         cfg[pulse_pkg::reg_p2_width2] = pick(1, 20);
         cfg[pulse_pkg::reg_nut_width] = pick(1, 30);
         cfg[pulse_pkg::reg_nut_delay] = pick(0, 30);
         cfg[pulse_pkg::reg_period]    = pick(400, 600);
         write_all();
         wait_wraps(2);
      end

      cur_test = "midperiod";
      wait_wraps(1);
      while (m_count < act_set[0] / 2)
         @(negedge clk);
      cfg[pulse_pkg::reg_mode]   = pick(2, 4);
      cfg[pulse_pkg::reg_period] = pick(500, 700);
      write_all();                                     // Running period must stay as it was
      wait_wraps(2);

      $display("Checks finished with %0d errors", errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("Timeout: the test sequence was still running after %0d ns", watchdog_ns);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
src/pulse_pkg.sv
src/pulse_config.sv
src/pulse_timing.sv
src/pulse_sequencer.sv
src/receiver_protect.sv
src/pulse_top.sv
testbench/pulse_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= pulse_tb
FILELIST  ?= sources.f
BIN       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
